// File: build.f
design/simt_cfg_pkg.sv
design/simt_isa_pkg.sv
design/op_decode.sv
design/lane_execute.sv
design/jal_redirect.sv
design/simt_execute.sv
tests/simt_execute_tb.sv

// File: Bender.yml
package:
  name: simt_execute

sources:
  - design/simt_cfg_pkg.sv
  - design/simt_isa_pkg.sv
  - design/op_decode.sv
  - design/lane_execute.sv
  - design/jal_redirect.sv
  - design/simt_execute.sv
  - target: simulation
    files:
      - tests/simt_execute_tb.sv

// File: tests/simt_execute_tb.sv
`default_nettype none

module simt_execute_tb import simt_cfg_pkg::*, simt_isa_pkg::*; ();

    localparam int kind_alu = 0;
    localparam int kind_br = 1;
    localparam int kind_jal = 2;
    localparam int kind_sys = 3;
    localparam int kind_mix = 4;
    localparam int total_ops = 40 + 40 + 5 + 12 + 80;

    typedef struct packed {
        logic [WID_W-1:0]   wid;
        logic [REG_W-1:0]   rd;
        logic               wb;
        logic [LANES_W-1:0] data;
        logic               br_valid;
        logic               br_taken;
        logic [XLEN-1:0]    br_dest;
        logic               ret_valid;
        logic [XLEN-1:0]    ret_pc;
    } commit_exp_t;

    logic clk;
    logic reset;
    logic disp_valid;
    logic [WID_W-1:0] disp_wid;
    op_word_t disp_op;
    logic [XLEN-1:0] disp_pc;
    logic [REG_W-1:0] disp_rd;
    logic [LANES_W-1:0] disp_rs1;
    logic [LANES_W-1:0] disp_rs2;
    logic disp_ready;
    logic commit_valid;
    logic [WID_W-1:0] commit_wid;
    logic [REG_W-1:0] commit_rd;
    logic commit_wb;
    logic [LANES_W-1:0] commit_data;
    logic br_valid;
    logic br_taken;
    logic [XLEN-1:0] br_dest;
    logic commit_ready;
    logic [NUM_WARPS-1:0] overload_mask;
    logic [XLEN-1:0] ret_handler_addr;
    logic [NUM_WARPS-1:0] hits_clear;
    logic [NUM_WARPS-1:0] warp_hits;
    logic ret_pc_valid;
    logic [WID_W-1:0] ret_pc_wid;
    logic [XLEN-1:0] ret_pc;
    logic sim_ebreak;

    logic [31:0] lfsr_state = 32'hf222_43c4;
    logic [NUM_WARPS-1:0] model_hits = '0;
    logic [WID_W-1:0] jal_wid = '0;
    logic stall_en = 1'b0;
    int cyc = 0;
    int n_pass = 0;
    int n_fail = 0;
    commit_exp_t exp_q[$];
    int cyc_q[$];

    simt_execute simt_execute_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // taps 32, 22, 2 and 1, the new bit enters at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // what the commit port must show for one dispatched instruction
    function automatic commit_exp_t expected_commit(input op_word_t op,
            input logic [WID_W-1:0] wid, input logic [XLEN-1:0] pc,
            input logic [REG_W-1:0] rd, input logic [LANES_W-1:0] rs1,
            input logic [LANES_W-1:0] rs2, input logic [NUM_WARPS-1:0] mask,
            input logic [NUM_WARPS-1:0] hits);
        commit_exp_t e;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        logic [XLEN-1:0] offset;
        logic [XLEN-1:0] link;
        e = '0;
        e.wid = wid;
        e.rd = rd;
        if (op.alu.op_class == class_alu) begin
            e.wb = 1'b1;
            for (int i = 0; i < NUM_THREADS; i++) begin
                a = rs1[i*XLEN +: XLEN];
                b = op.alu.use_imm ? {{(XLEN-10){op.alu.imm[9]}}, op.alu.imm}
                                   : rs2[i*XLEN +: XLEN];
                case (op.alu.alu_op)
                    alu_add: r = a + b;
                    alu_sub: r = a - b;
                    alu_and: r = a & b;
                    alu_or:  r = a | b;
                    alu_xor: r = a ^ b;
                    alu_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: r = '0;
                endcase
                e.data[i*XLEN +: XLEN] = r;
            end
        end else begin
            offset = {{(XLEN-11){op.br.offset[10]}}, op.br.offset};
            link = pc + 32'd4;
            a = rs1[XLEN-1:0];
            b = rs2[XLEN-1:0];
            e.br_valid = 1'b1;
            e.br_dest = pc + offset * 4;
            case (op.br.br_op)
                br_beq: e.br_taken = (a == b);
                br_bne: e.br_taken = (a != b);
                br_blt: e.br_taken = ($signed(a) < $signed(b));
                br_jal: begin
                    e.br_taken = 1'b1;
                    e.wb = 1'b1;
                    e.data = {NUM_THREADS{link}};
                    // first jal of a marked warp is redirected to the handler
                    if (mask[wid] && !hits[wid]) begin
                        e.data = {NUM_THREADS{ret_handler_addr}};
                        e.ret_valid = 1'b1;
                        e.ret_pc = link;
                    end
                end
                default: e.br_valid = 1'b0;
            endcase
        end
        return e;
    endfunction

    task automatic mismatch(input string name, input logic [LANES_W-1:0] exp,
            input logic [LANES_W-1:0] act);
        $display("ERR t=%0t %s expected %0h got %0h", $time, name, exp, act);
        n_fail++;
    endtask

    // everything is sampled on the falling edge, away from the DUT's updates
    always @(negedge clk) begin : compare
        commit_exp_t e;
        int c0;
        int fails_before;
        logic eb_exp;
        logic rdy_exp;
        if (!reset) begin
            eb_exp = disp_valid && disp_ready && disp_wid == '0
                && disp_op.br.op_class == class_branch
                && (disp_op.br.br_op == br_ecall || disp_op.br.br_op == br_ebreak);
            if (sim_ebreak !== eb_exp) mismatch("sim_ebreak", eb_exp, sim_ebreak);
            // with both stages full a stalled commit side holds off dispatch
            rdy_exp = (exp_q.size() < 2) || commit_ready;
            if (disp_ready !== rdy_exp) mismatch("disp_ready", rdy_exp, disp_ready);
            if (commit_valid && commit_ready) begin
                if (exp_q.size() == 0) begin
                    $display("commit at %0t arrived with no instruction outstanding", $time);
                    n_fail++;
                end else begin
                    e = exp_q.pop_front();
                    c0 = cyc_q.pop_front();
                    fails_before = n_fail;
                    if (commit_wid !== e.wid) mismatch("commit_wid", e.wid, commit_wid);
                    if (commit_rd !== e.rd) mismatch("commit_rd", e.rd, commit_rd);
                    if (commit_wb !== e.wb) mismatch("commit_wb", e.wb, commit_wb);
                    if (e.wb && commit_data !== e.data) mismatch("commit_data", e.data, commit_data);
                    if (br_valid !== e.br_valid) mismatch("br_valid", e.br_valid, br_valid);
                    if (e.br_valid && br_taken !== e.br_taken) mismatch("br_taken", e.br_taken, br_taken);
                    if (e.br_valid && br_dest !== e.br_dest) mismatch("br_dest", e.br_dest, br_dest);
                    if (ret_pc_valid !== e.ret_valid) mismatch("ret_pc_valid", e.ret_valid, ret_pc_valid);
                    if (e.ret_valid && ret_pc_wid !== e.wid) mismatch("ret_pc_wid", e.wid, ret_pc_wid);
                    if (e.ret_valid && ret_pc !== e.ret_pc) mismatch("ret_pc", e.ret_pc, ret_pc);
                    if (!stall_en && cyc - c0 != 2) mismatch("commit latency", 2, cyc - c0);
                    if (n_fail == fails_before) n_pass++;
                end
            end else if (ret_pc_valid) begin
                $display("ret_pc_valid is high at %0t outside a commit beat", $time);
                n_fail++;
            end
            model_hits = model_hits & ~hits_clear;
            if (disp_valid && disp_ready) begin
                e = expected_commit(disp_op, disp_wid, disp_pc, disp_rd, disp_rs1, disp_rs2,
                                    overload_mask, model_hits);
                if (e.ret_valid) model_hits[disp_wid] = 1'b1;
                exp_q.push_back(e);
                cyc_q.push_back(cyc);
            end
        end
    end

    task automatic make_op(input int kind);
        int k;
        logic [2:0] code;
        k = kind;
        if (k == kind_mix) k = rand_bits(1) ? kind_alu : kind_br;
        disp_wid = (k == kind_jal) ? jal_wid : WID_W'(rand_bits(WID_W));
        disp_pc = rand_bits(XLEN) & ~32'h3;
        disp_rd = REG_W'(rand_bits(REG_W));
        for (int i = 0; i < NUM_THREADS; i++) begin
            disp_rs1[i*XLEN +: XLEN] = rand_bits(XLEN);
            disp_rs2[i*XLEN +: XLEN] = rand_bits(XLEN);
        end
        // equal lane-0 operands half the time so beq and bne both go either way
        if (rand_bits(1)) disp_rs2[XLEN-1:0] = disp_rs1[XLEN-1:0];
        code = 3'(rand_bits(3) % 6);
        if (k == kind_alu) begin
            disp_op.alu.op_class = class_alu;
            disp_op.alu.alu_op = alu_op_t'(code);
            disp_op.alu.use_imm = rand_bits(1);
            disp_op.alu.imm = 10'(rand_bits(10));
        end else begin
            if (k == kind_jal) code = br_jal;
            if (k == kind_sys) code = rand_bits(1) ? br_ecall : br_ebreak;
            disp_op.br.op_class = class_branch;
            disp_op.br.br_op = br_op_t'(code);
            disp_op.br.offset = 11'(rand_bits(11));
        end
    endtask

    task automatic run_ops(input int kind, input int count, input logic stalls);
        int sent;
        int gap;
        logic taken;
        sent = 0;
        gap = 0;
        stall_en = stalls;
        while (sent < count) begin
            @(negedge clk);
            taken = disp_valid && disp_ready;
            @(posedge clk);
            #2;
            commit_ready = stalls ? (rand_bits(2) != 0) : 1'b1;
            if (taken) begin
                disp_valid = 1'b0;
                sent++;
                gap = rand_bits(2) == 0 ? int'(rand_bits(2)) : 0;
            end
            if (!disp_valid && sent < count) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    make_op(kind);
                    disp_valid = 1'b1;
                end
            end
        end
        commit_ready = 1'b1;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_hits();
        if (warp_hits !== model_hits) mismatch("warp_hits", model_hits, warp_hits);
        else n_pass++;
    endtask

    task automatic finish_test(input string name, input int fails_before);
        $display("%s test finished with %0d failures", name, n_fail - fails_before);
    endtask

    initial begin
        #(total_ops * 40 * 20);
        $display("the run timed out with %0d instructions outstanding", exp_q.size());
        $display("Test failed");
        $finish;
    end

    initial begin : main
        int fb;
        reset = 1'b1;
        disp_valid = 1'b0;
        disp_wid = '0;
        disp_op = '0;
        disp_pc = '0;
        disp_rd = '0;
        disp_rs1 = '0;
        disp_rs2 = '0;
        commit_ready = 1'b1;
        overload_mask = '0;
        ret_handler_addr = 32'h0000_8a40;
        hits_clear = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        fb = n_fail;
        @(negedge clk);
        if (commit_valid !== 1'b0) mismatch("commit_valid", 0, commit_valid);
        if (ret_pc_valid !== 1'b0) mismatch("ret_pc_valid", 0, ret_pc_valid);
        check_hits();
        finish_test("reset", fb);
        @(posedge clk);
        #2;

        fb = n_fail;
        run_ops(kind_alu, 40, 1'b0);
        finish_test("alu", fb);
        fb = n_fail;
        run_ops(kind_br, 40, 1'b0);
        finish_test("branch", fb);

        // warp 1 is marked, its first jal overloads and later ones link normally
        fb = n_fail;
        overload_mask = 4'b1010;
        jal_wid = 2'd1;
        run_ops(kind_jal, 3, 1'b0);
        check_hits();
        hits_clear = 4'b0010;
        @(posedge clk);
        #2;
        hits_clear = '0;
        check_hits();
        run_ops(kind_jal, 2, 1'b1);
        check_hits();
        finish_test("overload", fb);

        fb = n_fail;
        run_ops(kind_sys, 12, 1'b0);
        finish_test("ecall/ebreak", fb);
        fb = n_fail;
        run_ops(kind_mix, 80, 1'b1);
        check_hits();
        finish_test("stall", fb);

        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && exp_q.size() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/simt_execute.sv
`default_nettype none

module simt_execute import simt_cfg_pkg::*, simt_isa_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 disp_valid,
    input  wire logic [WID_W-1:0]     disp_wid,
    input  wire op_word_t             disp_op,
    input  wire logic [XLEN-1:0]      disp_pc,
    input  wire logic [REG_W-1:0]     disp_rd,
    input  wire logic [LANES_W-1:0]   disp_rs1,
    input  wire logic [LANES_W-1:0]   disp_rs2,
    output logic                      disp_ready,
    output logic                      commit_valid,
    output logic [WID_W-1:0]          commit_wid,
    output logic [REG_W-1:0]          commit_rd,
    output logic                      commit_wb,
    output logic [LANES_W-1:0]        commit_data,
    output logic                      br_valid,
    output logic                      br_taken,
    output logic [XLEN-1:0]           br_dest,
    input  wire logic                 commit_ready,
    input  wire logic [NUM_WARPS-1:0] overload_mask,
    input  wire logic [XLEN-1:0]      ret_handler_addr,
    input  wire logic [NUM_WARPS-1:0] hits_clear,
    output logic [NUM_WARPS-1:0]      warp_hits,
    output logic                      ret_pc_valid,
    output logic [WID_W-1:0]          ret_pc_wid,
    output logic [XLEN-1:0]           ret_pc,
    output logic                      sim_ebreak
);
    // decode to execute
    logic               dec_valid;
    logic               dec_ready;
    op_class_t          dec_class;
    alu_op_t            dec_alu_op;
    br_op_t             dec_br_op;
    logic               dec_use_imm;
    logic [XLEN-1:0]    dec_imm;
    logic [WID_W-1:0]   dec_wid;
    logic [XLEN-1:0]    dec_pc;
    logic [REG_W-1:0]   dec_rd;
    logic [LANES_W-1:0] dec_rs1;
    logic [LANES_W-1:0] dec_rs2;

    // execute to result
    logic               ex_valid;
    logic               ex_ready;
    logic [WID_W-1:0]   ex_wid;
    logic [REG_W-1:0]   ex_rd;
    logic [LANES_W-1:0] ex_data;
    logic               ex_wb;
    logic               ex_is_jal;
    logic               ex_br_valid;
    logic               ex_br_taken;
    logic [XLEN-1:0]    ex_br_dest;

    op_decode op_decode_i (.*);

    lane_execute lane_execute_i (.*);

    jal_redirect jal_redirect_i (.*);

endmodule

`default_nettype wire

// File: design/jal_redirect.sv
`default_nettype none

module jal_redirect import simt_cfg_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 ex_valid,
    input  wire logic [WID_W-1:0]     ex_wid,
    input  wire logic [REG_W-1:0]     ex_rd,
    input  wire logic [LANES_W-1:0]   ex_data,
    input  wire logic                 ex_wb,
    input  wire logic                 ex_is_jal,
    input  wire logic                 ex_br_valid,
    input  wire logic                 ex_br_taken,
    input  wire logic [XLEN-1:0]      ex_br_dest,
    output logic                      ex_ready,
    output logic                      commit_valid,
    output logic [WID_W-1:0]          commit_wid,
    output logic [REG_W-1:0]          commit_rd,
    output logic                      commit_wb,
    output logic [LANES_W-1:0]        commit_data,
    output logic                      br_valid,
    output logic                      br_taken,
    output logic [XLEN-1:0]           br_dest,
    input  wire logic                 commit_ready,
    input  wire logic [NUM_WARPS-1:0] overload_mask,
    input  wire logic [XLEN-1:0]      ret_handler_addr,
    input  wire logic [NUM_WARPS-1:0] hits_clear,
    output logic [NUM_WARPS-1:0]      warp_hits,
    output logic                      ret_pc_valid,
    output logic [WID_W-1:0]          ret_pc_wid,
    output logic [XLEN-1:0]           ret_pc
);
    logic                 overload;
    logic                 overload_beat;
    logic [NUM_WARPS-1:0] hit_set;

    // no storage on this path, stalls come straight from the commit side
    assign ex_ready     = commit_ready;
    assign commit_valid = ex_valid;
    assign commit_wid   = ex_wid;
    assign commit_rd    = ex_rd;
    assign commit_wb    = ex_wb;
    assign br_valid     = ex_br_valid;
    assign br_taken     = ex_br_taken;
    assign br_dest      = ex_br_dest;

    // the first jal of a marked warp leaves the scheduler and enters the kernel
    assign overload      = ex_valid && ex_is_jal && overload_mask[ex_wid] && !warp_hits[ex_wid];
    assign overload_beat = overload && commit_ready;

    // link register receives the return handler instead of pc + 4
    assign commit_data = overload ? {NUM_THREADS{ret_handler_addr}} : ex_data;

    // the real link value goes out so the interrupt control can save it
    assign ret_pc_valid = overload_beat;
    assign ret_pc_wid   = ex_wid;
    assign ret_pc       = ex_data[XLEN-1:0];

    assign hit_set = overload_beat ? (NUM_WARPS'(1) << ex_wid) : '0;

    // a hit recorded in the same cycle as a clear survives it
    always_ff @(posedge clk) begin
        if (reset) begin
            warp_hits <= '0;
        end else begin
            warp_hits <= (warp_hits & ~hits_clear) | hit_set;
        end
    end

endmodule

`default_nettype wire

// File: design/lane_execute.sv
`default_nettype none

module lane_execute import simt_cfg_pkg::*, simt_isa_pkg::*; (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               dec_valid,
    input  wire op_class_t          dec_class,
    input  wire alu_op_t            dec_alu_op,
    input  wire br_op_t             dec_br_op,
    input  wire logic               dec_use_imm,
    input  wire logic [XLEN-1:0]    dec_imm,
    input  wire logic [WID_W-1:0]   dec_wid,
    input  wire logic [XLEN-1:0]    dec_pc,
    input  wire logic [REG_W-1:0]   dec_rd,
    input  wire logic [LANES_W-1:0] dec_rs1,
    input  wire logic [LANES_W-1:0] dec_rs2,
    output logic                    dec_ready,
    output logic                    ex_valid,
    output logic [WID_W-1:0]        ex_wid,
    output logic [REG_W-1:0]        ex_rd,
    output logic [LANES_W-1:0]      ex_data,
    output logic                    ex_wb,
    output logic                    ex_is_jal,
    output logic                    ex_br_valid,
    output logic                    ex_br_taken,
    output logic [XLEN-1:0]         ex_br_dest,
    input  wire logic               ex_ready
);
    logic [LANES_W-1:0] alu_data;
    logic [XLEN-1:0]    lane0_rs1;
    logic [XLEN-1:0]    lane0_rs2;
    logic [XLEN-1:0]    link_pc;
    logic [XLEN-1:0]    target_pc;
    logic               cond_met;
    logic               is_branch;
    logic               is_jal;
    logic               is_sys;
    logic [LANES_W-1:0] nxt_data;

    assign dec_ready = !ex_valid || ex_ready;

    // every lane runs the same operation on its own operands
    always_comb begin : lane_alu
        logic [XLEN-1:0] opa;
        logic [XLEN-1:0] opb;
        alu_data = '0;
        for (int i = 0; i < NUM_THREADS; i++) begin
            opa = dec_rs1[i*XLEN +: XLEN];
            opb = dec_use_imm ? dec_imm : dec_rs2[i*XLEN +: XLEN];
            case (dec_alu_op)
                alu_add: alu_data[i*XLEN +: XLEN] = opa + opb;
                alu_sub: alu_data[i*XLEN +: XLEN] = opa - opb;
                alu_and: alu_data[i*XLEN +: XLEN] = opa & opb;
                alu_or:  alu_data[i*XLEN +: XLEN] = opa | opb;
                alu_xor: alu_data[i*XLEN +: XLEN] = opa ^ opb;
                alu_slt: alu_data[i*XLEN +: XLEN] = XLEN'($signed(opa) < $signed(opb));
                default: alu_data[i*XLEN +: XLEN] = '0;
            endcase
        end
    end

    // branches are warp-uniform so lane 0 speaks for the whole warp
    assign lane0_rs1 = dec_rs1[XLEN-1:0];
    assign lane0_rs2 = dec_rs2[XLEN-1:0];
    assign link_pc   = dec_pc + XLEN'(LINK_STEP);
    assign target_pc = dec_pc + dec_imm;

    always_comb begin
        case (dec_br_op)
            br_beq:  cond_met = (lane0_rs1 == lane0_rs2);
            br_bne:  cond_met = (lane0_rs1 != lane0_rs2);
            br_blt:  cond_met = ($signed(lane0_rs1) < $signed(lane0_rs2));
            br_jal:  cond_met = 1'b1;
            default: cond_met = 1'b0;
        endcase
    end

    assign is_branch = (dec_class == class_branch);
    assign is_jal    = is_branch && (dec_br_op == br_jal);
    assign is_sys    = (dec_br_op == br_ecall) || (dec_br_op == br_ebreak);

    // only jal writes back among the branch ops, it links every lane
    assign nxt_data = !is_branch ? alu_data
                    : is_jal     ? {NUM_THREADS{link_pc}}
                    : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (dec_ready) begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            ex_wid      <= dec_wid;
            ex_rd       <= dec_rd;
            ex_data     <= nxt_data;
            ex_wb       <= !is_branch || is_jal;
            ex_is_jal   <= is_jal;
            ex_br_valid <= is_branch && !is_sys;
            ex_br_taken <= is_branch && cond_met;
            ex_br_dest  <= target_pc;
        end
    end

endmodule

`default_nettype wire

// File: design/op_decode.sv
`default_nettype none

module op_decode import simt_cfg_pkg::*, simt_isa_pkg::*; (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               disp_valid,
    input  wire logic [WID_W-1:0]   disp_wid,
    input  wire op_word_t           disp_op,
    input  wire logic [XLEN-1:0]    disp_pc,
    input  wire logic [REG_W-1:0]   disp_rd,
    input  wire logic [LANES_W-1:0] disp_rs1,
    input  wire logic [LANES_W-1:0] disp_rs2,
    output logic                    disp_ready,
    output logic                    dec_valid,
    output op_class_t               dec_class,
    output alu_op_t                 dec_alu_op,
    output br_op_t                  dec_br_op,
    output logic                    dec_use_imm,
    output logic [XLEN-1:0]         dec_imm,
    output logic [WID_W-1:0]        dec_wid,
    output logic [XLEN-1:0]         dec_pc,
    output logic [REG_W-1:0]        dec_rd,
    output logic [LANES_W-1:0]      dec_rs1,
    output logic [LANES_W-1:0]      dec_rs2,
    input  wire logic               dec_ready,
    output logic                    sim_ebreak
);
    op_class_t        disp_class;
    alu_op_t          nxt_alu_op;
    br_op_t           nxt_br_op;
    logic             nxt_use_imm;
    logic [XLEN-1:0]  nxt_imm;

    // both views agree on where the class lives
    assign disp_class = disp_op.alu.op_class;

    assign disp_ready = !dec_valid || dec_ready;

    always_comb begin
        nxt_alu_op  = alu_add;
        nxt_br_op   = br_beq;
        nxt_use_imm = 1'b0;
        if (disp_class == class_branch) begin
            nxt_br_op = disp_op.br.br_op;
            // word offset becomes a byte offset before it is extended
            nxt_imm   = XLEN'($signed({disp_op.br.offset, 2'b00}));
        end else begin
            nxt_alu_op  = disp_op.alu.alu_op;
            nxt_use_imm = disp_op.alu.use_imm;
            nxt_imm     = XLEN'(disp_op.alu.imm);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (disp_ready) begin
            dec_valid <= disp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid && disp_ready) begin
            dec_class   <= disp_class;
            dec_alu_op  <= nxt_alu_op;
            dec_br_op   <= nxt_br_op;
            dec_use_imm <= nxt_use_imm;
            dec_imm     <= nxt_imm;
            dec_wid     <= disp_wid;
            dec_pc      <= disp_pc;
            dec_rd      <= disp_rd;
            dec_rs1     <= disp_rs1;
            dec_rs2     <= disp_rs2;
        end
    end

    // pass/fail hook for bare-metal tests, only warp 0 ends a run
    assign sim_ebreak = disp_valid && disp_ready && (disp_wid == '0)
                     && (disp_class == class_branch)
                     && (disp_op.br.br_op == br_ecall || disp_op.br.br_op == br_ebreak);

endmodule

`default_nettype wire

// File: design/simt_isa_pkg.sv
`default_nettype none

// encoding of the 16-bit operation word seen by the execute stage
package simt_isa_pkg;

    typedef enum logic [1:0] {
        class_alu    = 2'd0,
        class_branch = 2'd1
    } op_class_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5
    } alu_op_t;

    typedef enum logic [2:0] {
        br_beq    = 3'd0,
        br_bne    = 3'd1,
        br_blt    = 3'd2,
        br_jal    = 3'd3,
        br_ecall  = 3'd4,
        br_ebreak = 3'd5
    } br_op_t;

    // ALU form, second operand is rs2 or the immediate
    typedef struct packed {
        op_class_t         op_class;
        alu_op_t           alu_op;
        logic              use_imm;
        logic signed [9:0] imm;
    } alu_view_t;

    // branch form, the offset counts words relative to pc
    typedef struct packed {
        op_class_t          op_class;
        br_op_t             br_op;
        logic signed [10:0] offset;
    } br_view_t;

    // the class field sits in the same bits in both views
    typedef union packed {
        alu_view_t alu;
        br_view_t  br;
    } op_word_t;

    // a jal links to the next instruction
    localparam int unsigned LINK_STEP = 4;

endpackage

`default_nettype wire

// File: design/simt_cfg_pkg.sv
`default_nettype none

// sizes shared by every stage of the execute pipeline
package simt_cfg_pkg;

    // warps resident in the core
    localparam int unsigned NUM_WARPS = 4;

    // lanes per warp, all of them execute the same instruction
    localparam int unsigned NUM_THREADS = 4;

    // architectural word width
    localparam int unsigned XLEN = 32;

    // width of a warp id
    localparam int unsigned WID_W = $clog2(NUM_WARPS);

    // one operand or result vector holds a word per lane, lane 0 in the low bits
    localparam int unsigned LANES_W = NUM_THREADS * XLEN;

    // destination register index
    localparam int unsigned REG_W = 5;

endpackage

`default_nettype wire
